/* logic/ec_pkg.sv */
`default_nettype none

package ec_pkg;

	localparam int num_regs = 8; // register file size
	localparam int rom_depth = 62; // point-add program length

	typedef logic [2:0] reg_idx_t;
	typedef logic [5:0] pc_t;

	localparam reg_idx_t reg_px = 3'd0; // first operand x, result x
	localparam reg_idx_t reg_py = 3'd1; // first operand y, result y
	localparam reg_idx_t reg_qx = 3'd2;
	localparam reg_idx_t reg_qy = 3'd3;
	localparam reg_idx_t reg_t4 = 3'd4; // scratch, P infinity flag on load
	localparam reg_idx_t reg_t5 = 3'd5; // scratch, Q infinity flag on load
	localparam reg_idx_t reg_neg_a = 3'd6; // constant -a mod p
	localparam reg_idx_t reg_zero = 3'd7; // constant zero

	// instruction class in the top two bits
	localparam logic [1:0] cls_load = 2'b00;
	localparam logic [1:0] cls_arith = 2'b01;
	localparam logic [1:0] cls_jz = 2'b10; // offset 0 ends with failure
	localparam logic [1:0] cls_jnz = 2'b11; // offset 0 ends with success

	typedef enum logic [2:0] {
		op_sub = 3'd0, // a - b, result also into latch a
		op_mul = 3'd1,
		op_inv = 3'd2,
		op_mov = 3'd3,
		op_tstz = 3'd4 // flag from the named register
	} arith_op_t;

	typedef struct packed {
		logic [1:0] cls;
		reg_idx_t a; // into operand latch a
		reg_idx_t b; // into operand latch b
	} ld_word_t;

	typedef struct packed {
		logic [1:0] cls;
		arith_op_t op;
		reg_idx_t dest; // writeback target, tstz source
	} arith_word_t;

	typedef struct packed {
		logic [1:0] cls;
		logic [5:0] offset; // forward, relative to own pc
	} jump_word_t;

	typedef union packed {
		ld_word_t ld;
		arith_word_t ar;
		jump_word_t jmp;
	} instr_t;

endpackage

`default_nettype wire

/* logic/field_inverter.sv */
`timescale 1ns/1ps
`default_nettype none

module field_inverter #(
	parameter int unsigned field_bits = 16,
	parameter logic [field_bits-1:0] modulus = 16'hfff1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic inv_start,
	input wire logic [field_bits-1:0] inv_a,
	output logic inv_done,
	output logic [field_bits-1:0] inv_result
);

	logic running;
	logic [field_bits-1:0] u, v, x1, x2; // invariants x1*a = u, x2*a = v
	logic finish;

	// x/2 mod p, odd x gets p added first
	function automatic logic [field_bits-1:0] half_mod(input logic [field_bits-1:0] x);
		logic [field_bits:0] t;
		t = x[0] ? {1'b0, x} + {1'b0, modulus} : {1'b0, x};
		return t[field_bits:1];
	endfunction

	function automatic logic [field_bits-1:0] sub_mod(input logic [field_bits-1:0] a,
		input logic [field_bits-1:0] b);
		logic [field_bits:0] d;
		d = {1'b0, a} - {1'b0, b};
		return d[field_bits] ? d[field_bits-1:0] + modulus : d[field_bits-1:0];
	endfunction

	assign finish = running && (u == 1 || v == 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			inv_done <= 1'b0;
		end else begin
			inv_done <= finish;
			if (inv_start)
				running <= 1'b1;
			else if (finish)
				running <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inv_start) begin
			u <= inv_a;
			v <= modulus;
			x1 <= 1;
			x2 <= '0;
		end else if (finish)
			inv_result <= (u == 1) ? x1 : x2;
		else if (running) begin
			if (!u[0]) begin // one reduction step per cycle
				u <= u >> 1;
				x1 <= half_mod(x1);
			end else if (!v[0]) begin
				v <= v >> 1;
				x2 <= half_mod(x2);
			end else if (u >= v) begin
				u <= u - v;
				x1 <= sub_mod(x1, x2);
			end else begin
				v <= v - u;
				x2 <= sub_mod(x2, x1);
			end
		end
	end

endmodule

`default_nettype wire

/* logic/field_arith_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module field_arith_unit #(
	parameter int unsigned field_bits = 16,
	parameter logic [field_bits-1:0] modulus = 16'hfff1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic ld_en,
	input wire logic [field_bits-1:0] opnd_a,
	input wire logic [field_bits-1:0] opnd_b,
	input wire ec_pkg::arith_op_t op,
	input wire logic op_start,
	output logic op_done,
	output logic [field_bits-1:0] result,
	output logic zero_flag,
	output logic inv_start,
	output logic [field_bits-1:0] inv_a,
	input wire logic inv_done,
	input wire logic [field_bits-1:0] inv_result
);

	localparam int cnt_w = $clog2(field_bits + 1);
	localparam logic [1:0] md_idle = 2'd0;
	localparam logic [1:0] md_mul = 2'd1;
	localparam logic [1:0] md_inv = 2'd2;

	logic [1:0] mode;
	logic [cnt_w-1:0] cnt; // multiplier bits left
	logic [field_bits-1:0] lat_a, lat_b, sub_val, m_acc, m_b, dbl_red, mul_next;
	logic [field_bits:0] diff, dbl, dbl_sub, sum_w, sum_sub;

	assign diff = {1'b0, lat_a} - {1'b0, lat_b};
	assign sub_val = diff[field_bits] ? diff[field_bits-1:0] + modulus : diff[field_bits-1:0];

	// msb first, acc = 2*acc + a*bit, reduced after each half
	assign dbl = {m_acc, 1'b0};
	assign dbl_sub = dbl - {1'b0, modulus};
	assign dbl_red = dbl_sub[field_bits] ? dbl[field_bits-1:0] : dbl_sub[field_bits-1:0];
	assign sum_w = {1'b0, dbl_red} + (m_b[field_bits-1] ? {1'b0, lat_a} : '0);
	assign sum_sub = sum_w - {1'b0, modulus};
	assign mul_next = sum_sub[field_bits] ? sum_w[field_bits-1:0] : sum_sub[field_bits-1:0];

	assign inv_a = lat_a;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mode <= md_idle;
			cnt <= '0;
			op_done <= 1'b0;
			inv_start <= 1'b0;
			zero_flag <= 1'b0;
		end else begin
			op_done <= 1'b0;
			inv_start <= 1'b0;
			if (op_start) begin
				case (op)
					ec_pkg::op_mul: begin
						mode <= md_mul;
						cnt <= cnt_w'(field_bits - 1);
					end
					ec_pkg::op_inv: begin
						mode <= md_inv;
						inv_start <= 1'b1;
					end
					ec_pkg::op_tstz: begin
						zero_flag <= (opnd_a == '0); // live read of the dest register
						op_done <= 1'b1;
					end
					default: op_done <= 1'b1; // sub and mov, single cycle
				endcase
			end else if (mode == md_mul) begin
				if (cnt == '0) begin
					mode <= md_idle;
					op_done <= 1'b1;
				end else
					cnt <= cnt - 1'b1;
			end else if (mode == md_inv && inv_done) begin
				mode <= md_idle;
				op_done <= 1'b1;
			end
		end
	end

	// results also go back into latch a, the program chains on it
	always_ff @(posedge clk) begin
		if (ld_en) begin
			lat_a <= opnd_a;
			lat_b <= opnd_b;
		end else if (op_start) begin
			case (op)
				ec_pkg::op_sub: begin
					result <= sub_val;
					lat_a <= sub_val;
				end
				ec_pkg::op_mov: result <= lat_a;
				ec_pkg::op_mul: begin
					m_acc <= '0;
					m_b <= lat_b;
				end
				default: ;
			endcase
		end else if (mode == md_mul) begin
			m_acc <= mul_next;
			m_b <= m_b << 1;
			if (cnt == '0) begin
				result <= mul_next;
				lat_a <= mul_next;
			end
		end else if (mode == md_inv && inv_done) begin
			result <= inv_result;
			lat_a <= inv_result;
		end
	end

	a_opnd_reduced: assert property (@(posedge clk) disable iff (reset)
		ld_en |=> (lat_a < modulus && lat_b < modulus));

endmodule

`default_nettype wire

/* logic/field_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module field_reg_file #(
	parameter int unsigned field_bits = 16,
	parameter logic [field_bits-1:0] modulus = 16'hfff1,
	parameter int unsigned curve_a = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic load,
	input wire logic [field_bits-1:0] acc_x,
	input wire logic [field_bits-1:0] acc_y,
	input wire logic acc_inf,
	input wire logic [field_bits-1:0] q_x,
	input wire logic [field_bits-1:0] q_y,
	input wire logic q_inf,
	input wire ec_pkg::reg_idx_t rd_a,
	input wire ec_pkg::reg_idx_t rd_b,
	output logic [field_bits-1:0] rd_data_a,
	output logic [field_bits-1:0] rd_data_b,
	input wire logic wr_en,
	input wire ec_pkg::reg_idx_t wr_idx,
	input wire logic [field_bits-1:0] wr_data,
	output logic [field_bits-1:0] sum_x,
	output logic [field_bits-1:0] sum_y
);

	localparam logic [field_bits-1:0] a_red = field_bits'(curve_a % modulus);
	localparam logic [field_bits-1:0] neg_a = (a_red == '0) ? '0 : modulus - a_red;
	localparam int num_wr = ec_pkg::num_regs - 2; // r6 r7 are constants

	logic [field_bits-1:0] regs [num_wr]; // r0 to r5 only

	// constants decoded on the read side, fixed, never written
	assign rd_data_a = (rd_a == ec_pkg::reg_neg_a) ? neg_a :
		(rd_a == ec_pkg::reg_zero) ? '0 : regs[rd_a];
	assign rd_data_b = (rd_b == ec_pkg::reg_neg_a) ? neg_a :
		(rd_b == ec_pkg::reg_zero) ? '0 : regs[rd_b];
	assign sum_x = regs[ec_pkg::reg_px]; // result point lands in r0 r1
	assign sum_y = regs[ec_pkg::reg_py];

	always_ff @(posedge clk) begin
		if (load) begin
			regs[ec_pkg::reg_px] <= acc_x;
			regs[ec_pkg::reg_py] <= acc_y;
			regs[ec_pkg::reg_qx] <= q_x;
			regs[ec_pkg::reg_qy] <= q_y;
			regs[ec_pkg::reg_t4] <= field_bits'(acc_inf); // flags for the tstz checks
			regs[ec_pkg::reg_t5] <= field_bits'(q_inf);
		end else if (wr_en)
			regs[wr_idx] <= wr_data;
	end

	a_no_const_write: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (wr_idx != ec_pkg::reg_neg_a && wr_idx != ec_pkg::reg_zero));

endmodule

`default_nettype wire

/* logic/point_add_microcode.sv */
`timescale 1ns/1ps
`default_nettype none

module point_add_microcode (
	input wire ec_pkg::pc_t pc,
	output ec_pkg::instr_t instr
);

	// r0,r1 = P  r2,r3 = Q  r4,r5 = infinity flags on entry
	always_comb begin
		case (pc)
			6'd0: instr = 8'b01100100; // tstz r4, P at infinity?
			6'd1: instr = 8'b10001001; // jz +9, P finite
			6'd2: instr = 8'b01100101; // tstz r5
			6'd3: instr = 8'b11000110; // jnz +6, both infinite
			6'd4: instr = 8'b00010000; // ldo r2, r0
			6'd5: instr = 8'b01011000; // mov r0, result is Q
			6'd6: instr = 8'b00011000; // ldo r3, r0
			6'd7: instr = 8'b01011001; // mov r1
			6'd8: instr = 8'b11000000; // end ok
			6'd9: instr = 8'b10000000; // end infinity
			6'd10: instr = 8'b01100101; // tstz r5, Q at infinity?
			6'd11: instr = 8'b10000010; // jz +2, both finite
			6'd12: instr = 8'b11000000; // end ok, P already in r0 r1
			6'd13: instr = 8'b00000010; // ldo r0, r2
			6'd14: instr = 8'b01000100; // sub r4 = px - qx
			6'd15: instr = 8'b01100100; // tstz r4
			6'd16: instr = 8'b10001000; // jz +8, same x
			6'd17: instr = 8'b00100000; // ldo r4, r0
			6'd18: instr = 8'b01010100; // inv r4
			6'd19: instr = 8'b00001011; // ldo r1, r3
			6'd20: instr = 8'b01000101; // sub r5 = py - qy
			6'd21: instr = 8'b00100101; // ldo r4, r5
			6'd22: instr = 8'b01001100; // mul r4 = slope
			6'd23: instr = 8'b11010110; // jnz +22, flag still clear
			6'd24: instr = 8'b00001011; // ldo r1, r3, same x path
			6'd25: instr = 8'b01000100; // sub r4 = py - qy
			6'd26: instr = 8'b01100100; // tstz r4
			6'd27: instr = 8'b10000010; // jz +2, doubling
			6'd28: instr = 8'b10000000; // P = -Q, end infinity
			6'd29: instr = 8'b00111011; // ldo r7, r3
			6'd30: instr = 8'b01000100; // sub r4 = -y
			6'd31: instr = 8'b00011100; // ldo r3, r4
			6'd32: instr = 8'b01000011; // sub r3 = 2y, also latch a
			6'd33: instr = 8'b01010011; // inv r3
			6'd34: instr = 8'b00010010; // ldo r2, r2
			6'd35: instr = 8'b01001101; // mul r5 = x^2
			6'd36: instr = 8'b00111101; // ldo r7, r5
			6'd37: instr = 8'b01000100; // sub r4 = -x^2
			6'd38: instr = 8'b00101100; // ldo r5, r4
			6'd39: instr = 8'b01000101; // sub r5 = 2x^2
			6'd40: instr = 8'b01000101; // sub r5 = 3x^2 off latch a
			6'd41: instr = 8'b00101110; // ldo r5, r6
			6'd42: instr = 8'b01000100; // sub r4 = 3x^2 + a
			6'd43: instr = 8'b00011100; // ldo r3, r4
			6'd44: instr = 8'b01001100; // mul r4 = slope
			6'd45: instr = 8'b00100100; // ldo r4, r4, common tail
			6'd46: instr = 8'b01001101; // mul r5 = s^2
			6'd47: instr = 8'b00101000; // ldo r5, r0
			6'd48: instr = 8'b01000101; // sub r5
			6'd49: instr = 8'b00101010; // ldo r5, r2
			6'd50: instr = 8'b01000010; // sub r2 = new x
			6'd51: instr = 8'b00010000; // ldo r2, r0
			6'd52: instr = 8'b01000011; // sub r3 = x3 - px
			6'd53: instr = 8'b00011100; // ldo r3, r4
			6'd54: instr = 8'b01001011; // mul r3
			6'd55: instr = 8'b00111001; // ldo r7, r1
			6'd56: instr = 8'b01000001; // sub r1 = -py
			6'd57: instr = 8'b00001011; // ldo r1, r3
			6'd58: instr = 8'b01000001; // sub r1 = new y
			6'd59: instr = 8'b00010000; // ldo r2, r0
			6'd60: instr = 8'b01011000; // mov r0 = new x
			6'd61: instr = 8'b11000000; // end ok
			default: instr = 8'b10000000; // past the end, fail
		endcase
	end

endmodule

`default_nettype wire

/* logic/point_add_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module point_add_sequencer (
	input wire logic clk,
	input wire logic reset,
	input wire logic add_start,
	output logic add_done,
	output logic add_ok,
	output ec_pkg::pc_t pc,
	input wire ec_pkg::instr_t instr,
	output ec_pkg::reg_idx_t rd_a,
	output ec_pkg::reg_idx_t rd_b,
	output logic wr_en,
	output ec_pkg::reg_idx_t wr_idx,
	output logic ld_en,
	output ec_pkg::arith_op_t op,
	output logic op_start,
	input wire logic op_done,
	input wire logic zero_flag
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_run = 2'd1; // fetch and execute
	localparam logic [1:0] st_wait = 2'd2; // arith op outstanding

	logic [1:0] state;
	logic running, waiting, is_load, is_arith, is_term, take_jump;

	assign running = (state == st_run);
	assign waiting = (state == st_wait);
	assign is_load = (instr.ld.cls == ec_pkg::cls_load);
	assign is_arith = (instr.ar.cls == ec_pkg::cls_arith);
	assign is_term = (instr.jmp.offset == 6'd0); // only meaningful for jumps
	assign take_jump = (instr.jmp.cls == ec_pkg::cls_jz) ? zero_flag : !zero_flag;

	// arith words read their dest on port a, tstz needs it
	assign rd_a = is_load ? instr.ld.a : instr.ar.dest;
	assign rd_b = instr.ld.b; // port b only matters for loads
	assign ld_en = running && is_load;
	assign op = instr.ar.op;
	assign op_start = running && is_arith;
	assign wr_idx = instr.ar.dest; // instr held while waiting
	assign wr_en = waiting && op_done && (instr.ar.op != ec_pkg::op_tstz);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			pc <= '0;
			add_done <= 1'b0;
			add_ok <= 1'b0;
		end else begin
			add_done <= 1'b0;
			case (state)
				st_idle: if (add_start) begin
					pc <= '0;
					state <= st_run;
				end
				st_run: begin
					if (is_load)
						pc <= pc + 1'b1;
					else if (is_arith)
						state <= st_wait;
					else if (is_term) begin
						add_done <= 1'b1;
						add_ok <= (instr.jmp.cls == ec_pkg::cls_jnz); // jnz form means success
						state <= st_idle;
					end else if (take_jump)
						pc <= pc + instr.jmp.offset;
					else
						pc <= pc + 1'b1;
				end
				st_wait: if (op_done) begin
					pc <= pc + 1'b1;
					state <= st_run;
				end
				default: state <= st_idle;
			endcase
		end
	end

	a_instr_known: assert property (@(posedge clk) disable iff (reset)
		running |-> !$isunknown(instr));

endmodule

`default_nettype wire

/* logic/scalar_mul_loop.sv */
`timescale 1ns/1ps
`default_nettype none

module scalar_mul_loop #(
	parameter int unsigned field_bits = 16,
	parameter int unsigned scalar_bits = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic [scalar_bits-1:0] k,
	input wire logic [field_bits-1:0] p_x,
	input wire logic [field_bits-1:0] p_y,
	input wire logic p_inf,
	output logic busy,
	output logic done,
	output logic [field_bits-1:0] r_x,
	output logic [field_bits-1:0] r_y,
	output logic r_inf,
	output logic add_start,
	output logic [field_bits-1:0] acc_x,
	output logic [field_bits-1:0] acc_y,
	output logic acc_inf,
	output logic [field_bits-1:0] q_x,
	output logic [field_bits-1:0] q_y,
	output logic q_inf,
	input wire logic add_done,
	input wire logic add_ok,
	input wire logic [field_bits-1:0] sum_x,
	input wire logic [field_bits-1:0] sum_y
);

	localparam int idx_w = (scalar_bits > 1) ? $clog2(scalar_bits) : 1;

	logic [scalar_bits-1:0] k_q; // captured scalar
	logic [field_bits-1:0] px_q, py_q;
	logic pinf_q;
	logic [idx_w-1:0] idx; // current bit, msb first
	logic phase_add; // 0 doubling, 1 adding P
	logic pending; // addition in flight

	// doubling adds acc to itself, add phase uses P or infinity for a 0 bit
	assign q_x = phase_add ? px_q : acc_x;
	assign q_y = phase_add ? py_q : acc_y;
	assign q_inf = phase_add ? (pinf_q | ~k_q[idx]) : acc_inf;

	assign r_x = acc_x; // only moves after an accepted start
	assign r_y = acc_y;
	assign r_inf = acc_inf;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			add_start <= 1'b0;
			acc_inf <= 1'b1;
			phase_add <= 1'b0;
			idx <= '0;
			pending <= 1'b0;
		end else begin
			done <= 1'b0;
			add_start <= 1'b0;
			if (add_start)
				pending <= 1'b1;
			if (start && !busy) begin
				busy <= 1'b1;
				acc_inf <= 1'b1; // acc starts at infinity
				idx <= idx_w'(scalar_bits - 1);
				phase_add <= 1'b0;
				add_start <= 1'b1;
			end else if (add_done) begin
				pending <= 1'b0;
				acc_inf <= ~add_ok; // failed add means infinity
				if (!phase_add) begin
					phase_add <= 1'b1;
					add_start <= 1'b1;
				end else if (idx == '0) begin
					busy <= 1'b0; // falls with the done pulse
					done <= 1'b1;
				end else begin
					idx <= idx - 1'b1;
					phase_add <= 1'b0;
					add_start <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			k_q <= k;
			px_q <= p_x;
			py_q <= p_y;
			pinf_q <= p_inf;
		end else if (add_done) begin
			acc_x <= sum_x;
			acc_y <= sum_y;
		end
	end

	// one addition at a time through the sequencer
	a_one_add: assert property (@(posedge clk) disable iff (reset)
		add_start |-> !pending);

	// sequencer answers only a request in flight
	a_add_answered: assert property (@(posedge clk) disable iff (reset)
		add_done |-> pending);

endmodule

`default_nettype wire

/* logic/ec_scalar_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module ec_scalar_mul #(
	parameter int unsigned field_bits = 16,
	parameter logic [field_bits-1:0] modulus = 16'hfff1, // 65521
	parameter int unsigned curve_a = 2,
	parameter int unsigned scalar_bits = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic [scalar_bits-1:0] k,
	input wire logic [field_bits-1:0] p_x,
	input wire logic [field_bits-1:0] p_y,
	input wire logic p_inf,
	output logic busy,
	output logic done,
	output logic [field_bits-1:0] r_x,
	output logic [field_bits-1:0] r_y,
	output logic r_inf
);

	logic add_start, add_done, add_ok, acc_inf, q_inf;
	logic [field_bits-1:0] acc_x, acc_y, q_x, q_y, sum_x, sum_y;
	ec_pkg::pc_t pc;
	ec_pkg::instr_t instr;
	ec_pkg::reg_idx_t rd_a, rd_b, wr_idx;
	logic wr_en, ld_en, op_start, op_done, zero_flag;
	ec_pkg::arith_op_t op;
	logic [field_bits-1:0] rd_data_a, rd_data_b, result;
	logic inv_start, inv_done;
	logic [field_bits-1:0] inv_a, inv_result;

	scalar_mul_loop #(.field_bits(field_bits), .scalar_bits(scalar_bits)) u_loop (
		.clk(clk), .reset(reset), .start(start), .k(k), .p_x(p_x), .p_y(p_y),
		.p_inf(p_inf), .busy(busy), .done(done), .r_x(r_x), .r_y(r_y), .r_inf(r_inf),
		.add_start(add_start), .acc_x(acc_x), .acc_y(acc_y), .acc_inf(acc_inf),
		.q_x(q_x), .q_y(q_y), .q_inf(q_inf), .add_done(add_done), .add_ok(add_ok),
		.sum_x(sum_x), .sum_y(sum_y));

	point_add_sequencer u_seq (
		.clk(clk), .reset(reset), .add_start(add_start), .add_done(add_done),
		.add_ok(add_ok), .pc(pc), .instr(instr), .rd_a(rd_a), .rd_b(rd_b),
		.wr_en(wr_en), .wr_idx(wr_idx), .ld_en(ld_en), .op(op), .op_start(op_start),
		.op_done(op_done), .zero_flag(zero_flag));

	point_add_microcode u_rom (.pc(pc), .instr(instr));

	field_reg_file #(.field_bits(field_bits), .modulus(modulus), .curve_a(curve_a)) u_regs (
		.clk(clk), .reset(reset), .load(add_start), .acc_x(acc_x), .acc_y(acc_y),
		.acc_inf(acc_inf), .q_x(q_x), .q_y(q_y), .q_inf(q_inf), .rd_a(rd_a),
		.rd_b(rd_b), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .wr_en(wr_en),
		.wr_idx(wr_idx), .wr_data(result), .sum_x(sum_x), .sum_y(sum_y));

	field_arith_unit #(.field_bits(field_bits), .modulus(modulus)) u_alu (
		.clk(clk), .reset(reset), .ld_en(ld_en), .opnd_a(rd_data_a),
		.opnd_b(rd_data_b), .op(op), .op_start(op_start), .op_done(op_done),
		.result(result), .zero_flag(zero_flag), .inv_start(inv_start), .inv_a(inv_a),
		.inv_done(inv_done), .inv_result(inv_result));

	field_inverter #(.field_bits(field_bits), .modulus(modulus)) u_inv (
		.clk(clk), .reset(reset), .inv_start(inv_start), .inv_a(inv_a),
		.inv_done(inv_done), .inv_result(inv_result));

endmodule

`default_nettype wire

/* verification/tb_ec_scalar_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ec_scalar_mul;

	localparam int field_bits = 16;
	localparam logic [field_bits-1:0] modulus = 16'hfff1; // 65521, prime
	localparam int curve_a = 2;
	localparam int scalar_bits = 8;
	localparam int num_tests = 13; // rows in the pattern file
	localparam int row_words = 7; // k px py p_inf r_inf rx ry
	localparam int inv_bound = 4 * field_bits + 8; // binary euclid steps, with slack
	localparam int add_bound = 2 * ec_pkg::rom_depth + 4 * (field_bits + 2) + inv_bound;
	localparam int cycle_limit = (num_tests + 1) * scalar_bits * 2 * add_bound + 500;

	logic clk, reset, start, p_inf;
	logic busy, done, r_inf;
	logic [scalar_bits-1:0] k;
	logic [field_bits-1:0] p_x, p_y, r_x, r_y;

	logic [15:0] pat [num_tests * row_words]; // flat, row_words per test
	int unsigned rng;
	int errors, bad_tests, cycles;
	int done_count = 0; // done pulses seen so far

	ec_scalar_mul #(
		.field_bits(field_bits), .modulus(modulus), .curve_a(curve_a),
		.scalar_bits(scalar_bits)
	) u_ec_scalar_mul (
		.clk(clk), .reset(reset), .start(start), .k(k), .p_x(p_x), .p_y(p_y),
		.p_inf(p_inf), .busy(busy), .done(done), .r_x(r_x), .r_y(r_y), .r_inf(r_inf));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	always @(posedge clk) begin
		if (done)
			done_count <= done_count + 1;
	end

	// watchdog over the whole run
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the run hung waiting for done", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	function automatic int unsigned xorshift32(input int unsigned s);
		int unsigned x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1; // stay 1 ns past the edge
		end
	endtask

	task automatic drive_row(input int t);
		k = pat[t * row_words][scalar_bits-1:0];
		p_x = pat[t * row_words + 1];
		p_y = pat[t * row_words + 2];
		p_inf = pat[t * row_words + 3][0];
	endtask

	task automatic pulse_start();
		start = 1'b1;
		idle_cycles(1);
		start = 1'b0;
	endtask

	task automatic wait_done();
		while (!done)
			idle_cycles(1); // watchdog bounds this
	endtask

	task automatic check_result(input int t, input string name);
		logic exp_inf;
		logic [field_bits-1:0] exp_x, exp_y;
		exp_inf = pat[t * row_words + 4][0];
		exp_x = pat[t * row_words + 5];
		exp_y = pat[t * row_words + 6];
		assert (r_inf === exp_inf) else begin
			$display("ERR %s r_inf expected %0b actual %0b", name, exp_inf, r_inf);
			errors++;
		end
		if (!exp_inf) begin // coordinates are don't care at infinity
			assert (r_x === exp_x) else begin
				$display("ERR %s r_x expected %h actual %h", name, exp_x, r_x);
				errors++;
			end
			assert (r_y === exp_y) else begin
				$display("ERR %s r_y expected %h actual %h", name, exp_y, r_y);
				errors++;
			end
		end
	endtask

	task automatic check_one_done(input string name, input int count_before);
		assert (done_count == count_before + 1) else begin
			$display("ERR %s done pulses expected 1 actual %0d", name,
				done_count - count_before);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before)
			$display("%-16s ok", name);
		else begin
			$display("%-16s mismatch", name);
			bad_tests++;
		end
	endtask

	task automatic run_row(input int t);
		string name;
		int err_before, count_before;
		name = $sformatf("row%0d_k%02h", t, pat[t * row_words][7:0]);
		err_before = errors;
		count_before = done_count;
		drive_row(t);
		pulse_start();
		wait_done();
		assert (!busy) else begin
			$display("%s: busy still high in the cycle of done", name);
			errors++;
		end
		check_result(t, name);
		idle_cycles(2); // let the done counter catch up
		check_one_done(name, count_before);
		report_test(name, err_before);
	endtask

	// second start while busy must be dropped
	task automatic handshake_test();
		string name;
		int err_before, count_before;
		name = "handshake";
		err_before = errors;
		count_before = done_count;
		assert (!busy && !done) else begin
			$display("%s: busy or done high after reset", name);
			errors++;
		end
		drive_row(0);
		pulse_start();
		assert (busy) else begin
			$display("%s: busy did not rise after start", name);
			errors++;
		end
		idle_cycles(3);
		drive_row(11); // different request, should be ignored
		pulse_start();
		wait_done();
		check_result(0, name); // first request wins
		idle_cycles(3);
		check_one_done(name, count_before);
		assert (!busy) else begin
			$display("%s: busy stayed high after done", name);
			errors++;
		end
		report_test(name, err_before);
	endtask

	initial begin
		int gap;
		reset = 1'b1;
		start = 1'b0;
		k = '0;
		p_x = '0;
		p_y = '0;
		p_inf = 1'b0;
		errors = 0;
		bad_tests = 0;
		rng = 32'd42495; // fixed seed
		$readmemh("verification/ec_mul_patterns.hex", pat);
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		idle_cycles(1);
		handshake_test();
		for (int t = 0; t < num_tests; t++) begin
			rng = xorshift32(rng);
			gap = int'(rng % 4); // 0 to 3 idle cycles
			idle_cycles(gap);
			run_row(t);
		end
		$display("tests %0d, failing %0d, errors %0d", num_tests + 1, bad_tests, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
logic/ec_pkg.sv
logic/field_inverter.sv
logic/field_arith_unit.sv
logic/field_reg_file.sv
logic/point_add_microcode.sv
logic/point_add_sequencer.sv
logic/scalar_mul_loop.sv
logic/ec_scalar_mul.sv
verification/tb_ec_scalar_mul.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ec_scalar_mul testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ec_scalar_mul \
	-f compile.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verification/ec_mul_patterns.hex */
// columns: k  p_x  p_y  p_inf  r_inf  r_x  r_y   (hex, one test per row)
// field p = 65521, a = 2; curve 1 b = 1 with P = (0,1), curve 2 b = 41851 with P of order 3
05 0000 0001 0 0 87d2 1ad5 // 5P = (184/49, -2689/343)
03 0000 0001 0 0 0008 0017 // 3P = (8, 23)
06 0000 0001 0 0 9fab d8e4 // 6P = (945/529, 38998/12167)
04 0000 0001 0 0 6ff9 8bf8 // 4P = (-7/16, 13/64)
02 0000 0001 0 0 0001 ffef // 2P = (1, -2)
00 0000 0001 0 1 0000 0000 // k = 0
a5 0000 0001 1 1 0000 0000 // P at infinity
01 0000 0001 0 0 0000 0001 // k = 1 gives P
01 0003 2aad 0 0 0003 2aad // k = 1 on curve 2
03 0003 2aad 0 1 0000 0000 // k equals the order
ff 0003 2aad 0 1 0000 0000 // 255 = 3 * 85
fe 0003 2aad 0 0 0003 d544 // 254 = 2 mod 3, gives -P
02 0003 2aad 0 0 0003 d544 // 2P = -P
